// ==== src/rv_core_config.svh ====
// Core build parameters for the RV32I decode/execute pipeline
// Only RV_XLEN of 32 is supported by the decoder's immediate formats
// RV_ASSERT_ON is a value (1 or 0), tested in generate blocks
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// Data word width
`define RV_XLEN 32

// Architectural register index width, 32 registers
`define RV_REG_ADDR_W 5

// Concurrent assertions in the RTL, 1 = on
`define RV_ASSERT_ON 1

`endif

// ==== src/rv_core_pkg.sv ====
// Shared types and ALU operation codes for the RV32I pipeline
// Opcode and funct encodings are private to the decoder
`include "rv_core_config.svh"

package rv_core_pkg;

	// One data word
	typedef logic [`RV_XLEN-1:0] word_t;

	// Register index, x0 to x31
	typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

	// ALU operation selector
	typedef logic [3:0] alu_op_t;

	// Arithmetic
	localparam alu_op_t ALU_ADD    = 4'd0;
	localparam alu_op_t ALU_SUB    = 4'd1;

	// Compares, result is 0 or 1
	localparam alu_op_t ALU_SLT    = 4'd2;
	localparam alu_op_t ALU_SLTU   = 4'd3;

	// Bitwise logic
	localparam alu_op_t ALU_XOR    = 4'd4;
	localparam alu_op_t ALU_OR     = 4'd5;
	localparam alu_op_t ALU_AND    = 4'd6;

	// Shifts by the low 5 bits of operand b
	localparam alu_op_t ALU_SLL    = 4'd7;
	localparam alu_op_t ALU_SRL    = 4'd8;
	localparam alu_op_t ALU_SRA    = 4'd9;

	// Operand b straight through (LUI)
	localparam alu_op_t ALU_PASS_B = 4'd10;

endpackage

// ==== src/rv_regfile.sv ====
// 32-entry integer register file, x0 hardwired to zero
// Two combinational read ports with write-through bypass
// The writer must never target x0
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_regfile (
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  rv_core_pkg::reg_addr_t i_ra_addr,
	output rv_core_pkg::word_t     o_ra_data,
	input  rv_core_pkg::reg_addr_t i_rb_addr,
	output rv_core_pkg::word_t     o_rb_data,
	input  logic                   i_wr_en,
	input  rv_core_pkg::reg_addr_t i_wr_addr,
	input  rv_core_pkg::word_t     i_wr_data
);

	rv_core_pkg::word_t regs [1:31];

	// Shared read path for both ports
	function automatic rv_core_pkg::word_t read_port(input rv_core_pkg::reg_addr_t addr);
		if (addr == '0) begin
			return '0;
		end else if (i_wr_en && (i_wr_addr == addr)) begin
			return i_wr_data; // Bypass the same-cycle write
		end
		return regs[addr];
	endfunction

	always_comb begin
		o_ra_data = read_port(i_ra_addr);
		o_rb_data = read_port(i_rb_addr);
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wr_en && (i_wr_addr != '0)) begin
			regs[i_wr_addr] <= i_wr_data;
		end
	end

	if (`RV_ASSERT_ON) begin : g_assert
		a_no_x0_write: assert property (@(posedge i_clock) disable iff (i_reset)
			i_wr_en |-> (i_wr_addr != '0))
			else $error("register write targets x0");
	end

endmodule

// ==== src/rv_decode.sv ====
// Decode stage, a single register slot between fetch and execute
// Accepts OP, OP-IMM, LUI and AUIPC; everything else is flagged illegal
// Register reads are combinational from the offered word, so the
// regfile bypass must cover the write of the item in execute
// Illegal items carry rd = x0 and never write
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_decode (
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  logic                    i_hold,
	input  logic                    i_fetch_valid,
	input  rv_core_pkg::word_t      i_instr,
	input  rv_core_pkg::word_t      i_pc,
	output logic                    o_decode_accept,
	output rv_core_pkg::reg_addr_t  o_ra_addr,
	output rv_core_pkg::reg_addr_t  o_rb_addr,
	input  rv_core_pkg::word_t      i_ra_data,
	input  rv_core_pkg::word_t      i_rb_data,
	output logic                    o_valid,
	output rv_core_pkg::reg_addr_t  o_rd,
	output rv_core_pkg::alu_op_t    o_alu_op,
	output rv_core_pkg::word_t      o_op_a,
	output rv_core_pkg::word_t      o_op_b,
	output logic                    o_write,
	output logic                    o_illegal
);

	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

	logic [6:0]             opcode;
	logic [2:0]             funct3;
	logic [6:0]             funct7;
	rv_core_pkg::reg_addr_t rd;
	rv_core_pkg::word_t     imm_i;
	rv_core_pkg::word_t     imm_u;
	rv_core_pkg::word_t     shamt;
	logic                   is_op;
	logic                   is_op_imm;
	logic                   is_lui;
	logic                   is_auipc;
	logic                   f7_zero;
	logic                   f7_alt;
	logic                   legal;
	rv_core_pkg::alu_op_t   alu_op;
	rv_core_pkg::word_t     op_a;
	rv_core_pkg::word_t     op_b;

	assign opcode = i_instr[6:0];
	assign funct3 = i_instr[14:12];
	assign funct7 = i_instr[31:25];
	assign rd     = i_instr[11:7];

	assign imm_i = {{(`RV_XLEN-12){i_instr[31]}}, i_instr[31:20]};
	assign imm_u = {i_instr[31:12], 12'h000};
	assign shamt = {{(`RV_XLEN-5){1'b0}}, i_instr[24:20]}; // Zero-extended shift amount

	assign is_op     = (opcode == OPC_OP);
	assign is_op_imm = (opcode == OPC_OP_IMM);
	assign is_lui    = (opcode == OPC_LUI);
	assign is_auipc  = (opcode == OPC_AUIPC);

	assign f7_zero = (funct7 == 7'b0000000);
	assign f7_alt  = (funct7 == 7'b0100000); // SUB / SRA / SRAI form

	// Offered word is taken whenever not held
	assign o_decode_accept = i_fetch_valid && !i_hold;

	assign o_ra_addr = i_instr[19:15];
	assign o_rb_addr = i_instr[24:20];

	always_comb begin
		legal = 1'b0;
		if (is_op) begin
			legal = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
		end else if (is_op_imm) begin
			case (funct3)
				3'b001:  legal = f7_zero;           // SLLI
				3'b101:  legal = f7_zero || f7_alt; // SRLI / SRAI
				default: legal = 1'b1;              // funct7 is immediate
			endcase
		end else begin
			legal = is_lui || is_auipc;
		end
	end

	// Bit 30 only selects SUB (register form) and SRA
	always_comb begin
		alu_op = rv_core_pkg::ALU_ADD; // AUIPC adds PC + U-imm
		if (is_lui) begin
			alu_op = rv_core_pkg::ALU_PASS_B;
		end else if (is_op || is_op_imm) begin
			case (funct3)
				3'b000: alu_op = (is_op && i_instr[30]) ? rv_core_pkg::ALU_SUB
				                                        : rv_core_pkg::ALU_ADD;
				3'b001: alu_op = rv_core_pkg::ALU_SLL;
				3'b010: alu_op = rv_core_pkg::ALU_SLT;
				3'b011: alu_op = rv_core_pkg::ALU_SLTU;
				3'b100: alu_op = rv_core_pkg::ALU_XOR;
				3'b101: alu_op = i_instr[30] ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
				3'b110: alu_op = rv_core_pkg::ALU_OR;
				default: alu_op = rv_core_pkg::ALU_AND;
			endcase
		end
	end

	always_comb begin
		if (is_lui) begin
			op_a = '0;
		end else if (is_auipc) begin
			op_a = i_pc;
		end else begin
			op_a = i_ra_data;
		end

		if (is_op) begin
			op_b = i_rb_data;
		end else if (is_lui || is_auipc) begin
			op_b = imm_u;
		end else if (funct3 == 3'b001 || funct3 == 3'b101) begin
			op_b = shamt;
		end else begin
			op_b = imm_i;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_valid   <= 1'b0;
			o_write   <= 1'b0;
			o_illegal <= 1'b0;
		end else if (!i_hold) begin
			o_valid   <= i_fetch_valid;
			o_write   <= i_fetch_valid && legal && (rd != '0); // x0 writes dropped here
			o_illegal <= i_fetch_valid && !legal;
		end
	end

	// Payload only loads on accept
	always_ff @(posedge i_clock) begin
		if (o_decode_accept) begin
			o_rd     <= legal ? rd : '0;
			o_alu_op <= alu_op;
			o_op_a   <= op_a;
			o_op_b   <= op_b;
		end
	end

	if (`RV_ASSERT_ON) begin : g_assert
		a_valid_known: assert property (@(posedge i_clock) disable iff (i_reset)
			!$isunknown(o_valid))
			else $error("decode valid is unknown");
	end

endmodule

// ==== src/rv_exec.sv ====
// Execute stage: ALU, register write and registered write-back
// Register write happens in the same cycle the item sits in decode
// Illegal items report a zero result and never write
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_exec (
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_hold,
	input  logic                   i_valid,
	input  rv_core_pkg::reg_addr_t i_rd,
	input  rv_core_pkg::alu_op_t   i_alu_op,
	input  rv_core_pkg::word_t     i_op_a,
	input  rv_core_pkg::word_t     i_op_b,
	input  logic                   i_write,
	input  logic                   i_illegal,
	output logic                   o_wr_en,
	output rv_core_pkg::reg_addr_t o_wr_addr,
	output rv_core_pkg::word_t     o_wr_data,
	output logic                   o_wb_valid,
	output rv_core_pkg::reg_addr_t o_wb_rd,
	output rv_core_pkg::word_t     o_wb_data,
	output logic                   o_wb_illegal
);

	rv_core_pkg::word_t alu_result;
	logic [4:0]         shamt;

	assign shamt = i_op_b[4:0];

	always_comb begin
		case (i_alu_op)
			rv_core_pkg::ALU_ADD:    alu_result = i_op_a + i_op_b;
			rv_core_pkg::ALU_SUB:    alu_result = i_op_a - i_op_b;
			rv_core_pkg::ALU_SLT: begin
				alu_result = '0;
				alu_result[0] = ($signed(i_op_a) < $signed(i_op_b));
			end
			rv_core_pkg::ALU_SLTU: begin
				alu_result = '0;
				alu_result[0] = (i_op_a < i_op_b);
			end
			rv_core_pkg::ALU_XOR:    alu_result = i_op_a ^ i_op_b;
			rv_core_pkg::ALU_OR:     alu_result = i_op_a | i_op_b;
			rv_core_pkg::ALU_AND:    alu_result = i_op_a & i_op_b;
			rv_core_pkg::ALU_SLL:    alu_result = i_op_a << shamt;
			rv_core_pkg::ALU_SRL:    alu_result = i_op_a >> shamt;
			rv_core_pkg::ALU_SRA:    alu_result = $signed(i_op_a) >>> shamt; // Sign fill
			rv_core_pkg::ALU_PASS_B: alu_result = i_op_b;
			default:                 alu_result = '0;
		endcase
	end

	// Write in the cycle the item is here, unless frozen
	assign o_wr_en   = i_valid && i_write && !i_hold;
	assign o_wr_addr = i_rd;
	assign o_wr_data = alu_result;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_wb_valid   <= 1'b0;
			o_wb_illegal <= 1'b0;
		end else if (!i_hold) begin
			o_wb_valid   <= i_valid;
			o_wb_illegal <= i_valid && i_illegal;
		end
	end

	always_ff @(posedge i_clock) begin
		if (!i_hold && i_valid) begin
			o_wb_rd   <= i_rd;
			o_wb_data <= i_illegal ? '0 : alu_result;
		end
	end

	if (`RV_ASSERT_ON) begin : g_assert
		// Decode must never mark an illegal item writable
		a_wr_legal: assert property (@(posedge i_clock) disable iff (i_reset)
			o_wr_en |-> (i_valid && !i_illegal))
			else $error("register write from invalid or illegal item");
	end

endmodule

// ==== src/rv_core_top.sv ====
// RV32I decode/execute pipeline top
// Instructions arrive on a valid level, taken when i_hold is low
// Results appear on o_wb_* two cycles after acceptance
// i_hold freezes both stages and blocks register writes
`timescale 1ns/1ps

module rv_core_top (
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_hold,
	input  logic                   i_fetch_valid,
	input  rv_core_pkg::word_t     i_instr,
	input  rv_core_pkg::word_t     i_pc,
	output logic                   o_decode_accept,
	output logic                   o_wb_valid,
	output rv_core_pkg::reg_addr_t o_wb_rd,
	output rv_core_pkg::word_t     o_wb_data,
	output logic                   o_wb_illegal
);

	// Decode to execute
	logic                   d_valid;
	rv_core_pkg::reg_addr_t d_rd;
	rv_core_pkg::alu_op_t   d_alu_op;
	rv_core_pkg::word_t     d_op_a;
	rv_core_pkg::word_t     d_op_b;
	logic                   d_write;
	logic                   d_illegal;

	// Register file ports
	rv_core_pkg::reg_addr_t ra_addr;
	rv_core_pkg::reg_addr_t rb_addr;
	rv_core_pkg::word_t     ra_data;
	rv_core_pkg::word_t     rb_data;
	logic                   wr_en;
	rv_core_pkg::reg_addr_t wr_addr;
	rv_core_pkg::word_t     wr_data;

	rv_decode u_decode (
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_hold          (i_hold),
		.i_fetch_valid   (i_fetch_valid),
		.i_instr         (i_instr),
		.i_pc            (i_pc),
		.o_decode_accept (o_decode_accept),
		.o_ra_addr       (ra_addr),
		.o_rb_addr       (rb_addr),
		.i_ra_data       (ra_data),
		.i_rb_data       (rb_data),
		.o_valid         (d_valid),
		.o_rd            (d_rd),
		.o_alu_op        (d_alu_op),
		.o_op_a          (d_op_a),
		.o_op_b          (d_op_b),
		.o_write         (d_write),
		.o_illegal       (d_illegal)
	);

	rv_regfile u_regfile (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_ra_addr (ra_addr),
		.o_ra_data (ra_data),
		.i_rb_addr (rb_addr),
		.o_rb_data (rb_data),
		.i_wr_en   (wr_en),
		.i_wr_addr (wr_addr),
		.i_wr_data (wr_data)
	);

	rv_exec u_exec (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_hold       (i_hold),
		.i_valid      (d_valid),
		.i_rd         (d_rd),
		.i_alu_op     (d_alu_op),
		.i_op_a       (d_op_a),
		.i_op_b       (d_op_b),
		.i_write      (d_write),
		.i_illegal    (d_illegal),
		.o_wr_en      (wr_en),
		.o_wr_addr    (wr_addr),
		.o_wr_data    (wr_data),
		.o_wb_valid   (o_wb_valid),
		.o_wb_rd      (o_wb_rd),
		.o_wb_data    (o_wb_data),
		.o_wb_illegal (o_wb_illegal)
	);

endmodule

// ==== test/tb_rv_model.svh ====
// Reference model of the RV32I OP, OP-IMM, LUI and AUIPC subset
// Keeps its own 32-register copy, updated in program order at acceptance
// Illegal items expect rd = x0, zero data and no register change
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// One expected write-back, tag is the unheld cycle count at acceptance
typedef struct packed {
	logic [31:0] tag;
	logic        illegal;
	logic [4:0]  rd;
	logic [31:0] data;
} exp_item_t;

logic [31:0] model_regs [0:31];

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd);
	return {imm, rs1, f3, rd, 7'h13};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
	return {imm, rd, opc};
endfunction

// RV32I integer semantics by funct3, alt is instruction bit 30
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
	logic [31:0] y;
	case (f3)
		3'd0: y = alt ? a - b : a + b;
		3'd1: y = a << b[4:0];
		3'd2: y = {31'b0, $signed(a) < $signed(b)};
		3'd3: y = {31'b0, a < b};
		3'd4: y = a ^ b;
		3'd5: begin
			y = a >> b[4:0];
			if (alt)
				y = $signed(a) >>> b[4:0];
		end
		3'd6: y = a | b;
		default: y = a & b;
	endcase
	return y;
endfunction

function automatic exp_item_t reference(input logic [31:0] word, input logic [31:0] addr);
	exp_item_t   r;
	logic [6:0]  f7;
	logic [2:0]  f3;
	logic [31:0] a;
	logic        legal;
	f7 = word[31:25];
	f3 = word[14:12];
	a = model_regs[word[19:15]];
	r = '0;
	legal = 1'b1;
	case (word[6:0])
		7'h33: begin
			legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
			r.data = alu_ref(f3, f7[5], a, model_regs[word[24:20]]);
		end
		7'h13: begin
			if (f3 == 3'd1 || f3 == 3'd5) begin
				legal = (f7 == 7'h00) || (f3 == 3'd5 && f7 == 7'h20);
				r.data = alu_ref(f3, f7[5], a, {27'b0, word[24:20]});
			end else begin
				r.data = alu_ref(f3, 1'b0, a, {{20{word[31]}}, word[31:20]});
			end
		end
		7'h37: r.data = {word[31:12], 12'h000};
		7'h17: r.data = addr + {word[31:12], 12'h000};
		default: legal = 1'b0;
	endcase
	if (!legal) begin
		r = '0;
		r.illegal = 1'b1;
	end else begin
		r.rd = word[11:7];
		if (r.rd != 5'd0)
			model_regs[r.rd] = r.data; // x0 stays zero
	end
	return r;
endfunction

`endif

// ==== test/tb_rv_core.sv ====
// Testbench for the RV32I decode/execute pipeline
// Every write-back is checked against the model, in order, with its latency
// Random hold is applied only in the last test
`timescale 1ns/1ps

module tb_rv_core;

	`include "tb_rv_model.svh"

	localparam int CLK_PERIOD = 100;
	localparam int N_RAND     = 200;
	localparam int N_DEP      = 64;
	localparam int N_UPPER    = 40;
	localparam int N_ILLEGAL  = 32;
	localparam int N_HOLD     = 200;
	// Six passes over x1..x31 plus the x0 probe
	localparam int N_TOTAL = 31 * 6 + 1 + N_RAND + N_DEP + N_UPPER + N_ILLEGAL + N_HOLD;

	logic                   clock;
	logic                   reset;
	logic                   hold;
	logic                   fetch_valid;
	rv_core_pkg::word_t     instr;
	rv_core_pkg::word_t     pc;
	logic                   decode_accept;
	logic                   wb_valid;
	rv_core_pkg::reg_addr_t wb_rd;
	rv_core_pkg::word_t     wb_data;
	logic                   wb_illegal;

	logic [31:0] lcg_state = 32'he62e_1e15;
	logic        hold_random = 1'b0;
	logic [31:0] unheld_cycles = '0;
	int          checks = 0;
	int          errors = 0;
	int          instr_count = 0;
	exp_item_t   exp_q [$];

	rv_core_top dut (
		.i_clock         (clock),
		.i_reset         (reset),
		.i_hold          (hold),
		.i_fetch_valid   (fetch_valid),
		.i_instr         (instr),
		.i_pc            (pc),
		.o_decode_accept (decode_accept),
		.o_wb_valid      (wb_valid),
		.o_wb_rd         (wb_rd),
		.o_wb_data       (wb_data),
		.o_wb_illegal    (wb_illegal)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(CLK_PERIOD * (N_TOTAL * 4 + 50));
		$display("Timeout: the pipeline stalled with results still outstanding");
		$display("ERRORS FOUND");
		$finish;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail at %0t: %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	// Random OP or OP-IMM, shift amounts biased to 0 and 31
	function automatic logic [31:0] random_alu(input logic [4:0] rd, input logic [4:0] rs1);
		logic [31:0] r;
		logic [31:0] s;
		logic [4:0]  sh;
		logic [6:0]  f7;
		r = lcg_next();
		s = lcg_next();
		sh = (r[1:0] == 2'd0) ? 5'd0 : (r[1:0] == 2'd1) ? 5'd31 : s[4:0];
		f7 = r[2] ? 7'h20 : 7'h00;
		if (r[3]) begin
			if (r[6:4] != 3'd0 && r[6:4] != 3'd5)
				f7 = 7'h00; // Bit 30 only for SUB and SRA
			return enc_r(f7, s[24:20], rs1, r[6:4], rd);
		end
		if (r[6:4] == 3'd1 || r[6:4] == 3'd5)
			return enc_i({(r[6:4] == 3'd5) ? f7 : 7'h00, sh}, rs1, r[6:4], rd);
		return enc_i(s[31:20], rs1, r[6:4], rd);
	endfunction

	// Offer one instruction until it is taken
	task automatic send(input logic [31:0] word, input logic [31:0] addr);
		logic held;
		logic taken;
		taken = 1'b0;
		while (!taken) begin
			held = hold_random && ((lcg_next() >> 30) == 0);
			fetch_valid <= 1'b1;
			hold        <= held;
			instr       <= held ? lcg_next() : word; // Garbage while held
			pc          <= addr;
			@(posedge clock);
			taken = !held;
		end
	endtask

	task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
		send(enc_u(value[31:12] + value[11], rd, 7'h37), 32'h0);
		send(enc_i(value[11:0], rd, 3'd0, rd), 32'h0);
	endtask

	// ADD xk, xk, x0 shows each register on the write-back port
	task automatic read_back();
		for (int k = 1; k < 32; k++)
			send(enc_r(7'h00, 5'd0, k[4:0], 3'd0, k[4:0]), 32'h0);
	endtask

	task automatic end_test(input string name, input int err_before);
		fetch_valid <= 1'b0;
		hold        <= 1'b0;
		@(posedge clock);
		while (exp_q.size() != 0)
			@(posedge clock);
		$display("Test %s: %0d errors", name, errors - err_before);
	endtask

	// Compare process, pops results and pushes accepted items
	always @(posedge clock) begin
		exp_item_t item;
		if (!reset) begin
			check_value("o_decode_accept", fetch_valid && !hold, decode_accept);
			if (!hold && wb_valid) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("Error at %0t: a result appeared with nothing outstanding", $time);
				end else begin
					item = exp_q.pop_front();
					check_value("o_wb_rd", item.rd, wb_rd);
					check_value("o_wb_data", item.data, wb_data);
					check_value("o_wb_illegal", item.illegal, wb_illegal);
					check_value("result latency", 32'd2, unheld_cycles - item.tag);
				end
			end
			if (fetch_valid && !hold) begin
				item = reference(instr, pc);
				item.tag = unheld_cycles;
				exp_q.push_back(item);
				instr_count++;
			end
			if (!hold)
				unheld_cycles++;
		end
	end

	initial begin
		int          base;
		logic [31:0] r;
		logic [31:0] w;
		logic [4:0]  prev_rd;
		logic [4:0]  rd;
		reset = 1'b1;
		hold = 1'b0;
		fetch_valid = 1'b0;
		instr = '0;
		pc = '0;
		for (int k = 0; k < 32; k++)
			model_regs[k] = '0;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		check_value("o_wb_valid", 32'd0, wb_valid);

		base = errors;
		for (int k = 1; k < 32; k++)
			send(enc_i(12'(k * 97 - 1500), 5'd0, 3'd0, k[4:0]), 32'h0);
		read_back();
		end_test("1 register write and read", base);

		base = errors;
		for (int k = 1; k < 32; k++)
			load_reg(k[4:0], lcg_next());
		for (int n = 0; n < N_RAND; n++) begin
			r = lcg_next();
			send(random_alu(r[4:0], r[9:5]), 32'h0);
		end
		end_test("2 random ALU", base);

		base = errors;
		prev_rd = 5'd1;
		for (int n = 0; n < N_DEP; n++) begin
			rd = (n % 8 == 7) ? 5'd0 : 5'd1 + lcg_next() % 31; // Every 8th to x0
			send(random_alu(rd, prev_rd), 32'h0);
			prev_rd = rd;
		end
		send(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd1), 32'h0);
		end_test("3 dependent chain and x0", base);

		base = errors;
		for (int n = 0; n < N_UPPER; n++) begin
			r = lcg_next();
			send(enc_u(lcg_next() >> 12, r[4:0], r[5] ? 7'h37 : 7'h17),
				lcg_next() & 32'hffff_fffc);
		end
		end_test("4 LUI and AUIPC", base);

		base = errors;
		for (int n = 0; n < N_ILLEGAL; n++) begin
			r = lcg_next();
			w = r;
			if (r[6:0] == 7'h33 || r[6:0] == 7'h13 || r[6:0] == 7'h37 || r[6:0] == 7'h17)
				w[6:0] = 7'h63; // Branch opcode instead
			if (n % 3 == 1)
				w = enc_r({1'b1, r[30:25]}, r[24:20], r[19:15], r[14:12], r[11:7]);
			if (n % 3 == 2)
				w = enc_i({7'h20, r[24:20]}, r[19:15], 3'd1, r[11:7]);
			send(w, 32'h0);
		end
		read_back();
		end_test("5 illegal encodings", base);

		base = errors;
		hold_random = 1'b1;
		for (int n = 0; n < N_HOLD; n++) begin
			r = lcg_next();
			if (r[2:0] == 3'd0)
				send(enc_u(r[31:12], r[11:7], 7'h17), r & 32'hffff_fffc);
			else if (r[2:0] == 3'd1)
				send(enc_r(7'h01, r[24:20], r[19:15], 3'd0, r[11:7]), 32'h0); // M extension
			else
				send(random_alu(r[11:7], r[16:12]), 32'h0);
		end
		hold_random = 1'b0;
		read_back();
		end_test("6 random hold", base);

		$display("Summary: %0d instructions, %0d checks, %0d errors",
			instr_count, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+src
+incdir+test
src/rv_core_pkg.sv
src/rv_regfile.sv
src/rv_decode.sv
src/rv_exec.sv
src/rv_core_top.sv
test/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - include_dirs:
      - src
    files:
      - src/rv_core_pkg.sv
      - src/rv_regfile.sv
      - src/rv_decode.sv
      - src/rv_exec.sv
      - src/rv_core_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_rv_core.sv
